// File: verilog/ps2_pkg.sv
package ps2_pkg;

    // ####################
    // hub sizing

    localparam int NUM_PORTS  = 2;                                    // keyboard ports on the hub
    localparam int PORT_W     = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1;

    // ####################
    // frame receiver

    localparam int FRAME_BITS = 11;                                   // start, 8 data, parity, stop
    localparam int FIFO_DEPTH = 4;
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);

    // ####################
    // types and codes

    typedef logic [PORT_W-1:0] port_t;                                // port index
    typedef logic [7:0]        scan_t;                                // one scan code byte

    localparam scan_t BREAK_CODE = 8'hF0;                             // release prefix

    // release decoder states
    typedef enum logic [2:0]
    {
        IDLE,                                                         // wait for a byte
        FETCH,                                                        // pop head, latch it
        CHECK_MAKE,                                                   // break prefix or make
        WAIT_MAKE,                                                    // make dropped
        BREAK_WAIT,                                                   // wait for byte after F0
        FETCH_BRK,                                                    // pop byte after F0
        HOLD                                                          // release pending
    } rel_state_t;

endpackage

// File: verilog/ps2_sync.sv
`timescale 1ns/1ps

module ps2_sync (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [ps2_pkg::NUM_PORTS-1:0] ps2_clk,
    input  logic [ps2_pkg::NUM_PORTS-1:0] ps2_dat,
    output logic [ps2_pkg::NUM_PORTS-1:0] dat_s,
    output logic [ps2_pkg::NUM_PORTS-1:0] fall
);

    import ps2_pkg::*;

    logic [NUM_PORTS-1:0] clk_m;                                      // first stage
    logic [NUM_PORTS-1:0] clk_s;                                      // synchronized ps2 clock
    logic [NUM_PORTS-1:0] clk_prev;                                   // previous sample
    logic [NUM_PORTS-1:0] dat_m;
    logic [NUM_PORTS-1:0] dat_r;

    // ####################
    // ps2 clock, edge detect

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            clk_m    <= '1;
            clk_s    <= '1;
            clk_prev <= '1;                                           // idle bus level
            fall     <= '0;
        end
        else
        begin
            clk_m    <= ps2_clk;
            clk_s    <= clk_m;
            clk_prev <= clk_s;
            fall     <= clk_prev & ~clk_s;                            // one pulse per falling edge
        end
    end

    // ####################
    // ps2 data, same depth as fall

    always_ff @(posedge clk)
    begin
        dat_m <= ps2_dat;
        dat_r <= dat_m;
        dat_s <= dat_r;                                               // lines up with fall
    end

endmodule

// File: verilog/ps2_frame_rx.sv
`timescale 1ns/1ps

module ps2_frame_rx (
    input  logic           clk,
    input  logic           rst,
    input  logic           fall,
    input  logic           dat_s,
    input  logic           next_data,
    output logic           ready,
    output ps2_pkg::scan_t data
);

    import ps2_pkg::*;

    logic [3:0]            bit_cnt;                                   // bit position in frame
    logic [9:0]            shreg;                                     // parity, d7..d0, start
    logic                  frame_end;
    logic                  frame_ok;
    logic                  push;
    logic                  pop;

    scan_t                 mem [FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0] head;
    logic [FIFO_PTR_W-1:0] tail;
    logic [FIFO_PTR_W:0]   fill;

    // ####################
    // frame shifter

    assign frame_end = fall && (bit_cnt == 4'(FRAME_BITS - 1));      // stop bit arriving
    assign frame_ok  = !shreg[0] && dat_s && (^shreg[9:1]);           // start 0, stop 1, odd parity
    assign push      = frame_end && frame_ok;
    assign pop       = next_data;

    always_ff @(posedge clk)
    begin
        if (!rst)
            bit_cnt <= '0;
        else if (fall)
        begin
            if (frame_end)
                bit_cnt <= '0;
            else if (bit_cnt != '0 || !dat_s)                         // hold at 0 until a start bit
                bit_cnt <= bit_cnt + 4'd1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (fall && !frame_end)
            shreg <= {dat_s, shreg[9:1]};                             // lsb first
    end

    // ####################
    // byte fifo

    always_ff @(posedge clk)
    begin
        if (push)
            mem[tail] <= shreg[8:1];
    end

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            head <= '0;
            tail <= '0;
            fill <= '0;
        end
        else
        begin
            if (push)
                tail <= tail + 1'b1;
            if (pop)
                head <= head + 1'b1;
            case ({push, pop})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill;
            endcase
        end
    end

    assign ready = (fill != '0);
    assign data  = mem[head];                                         // head, valid while ready

    // the decoder drains far faster than frames arrive
    a_no_overflow : assert property (@(posedge clk) disable iff (!rst)
        push |-> (fill != (FIFO_PTR_W + 1)'(FIFO_DEPTH)))
        else $error("ps2_frame_rx: byte pushed into a full FIFO");

    a_no_underflow : assert property (@(posedge clk) disable iff (!rst)
        next_data |-> ready)
        else $error("ps2_frame_rx: pop from an empty FIFO");

endmodule

// File: verilog/ps2_channel.sv
`timescale 1ns/1ps

module ps2_channel (
    input  logic           clk,
    input  logic           rst,
    input  logic           fall,
    input  logic           dat_s,
    input  logic           rel_ack,
    output logic           rel_valid,
    output ps2_pkg::scan_t rel_code
);

    import ps2_pkg::*;

    rel_state_t state;
    rel_state_t state_nx;
    logic       ready;
    logic       next_data;
    scan_t      data;

    ps2_frame_rx frame_rx_i (
        .clk       (clk),
        .rst       (rst),
        .fall      (fall),
        .dat_s     (dat_s),
        .next_data (next_data),
        .ready     (ready),
        .data      (data)
    );

    // ####################
    // release decoder

    always_comb
    begin
        state_nx = state;
        case (state)
            IDLE:
                if (ready)
                    state_nx = FETCH;
            FETCH:
                state_nx = CHECK_MAKE;
            CHECK_MAKE:
                state_nx = (rel_code == BREAK_CODE) ? BREAK_WAIT : WAIT_MAKE;
            WAIT_MAKE:
                state_nx = IDLE;                                      // make byte discarded
            BREAK_WAIT:
                if (ready)
                    state_nx = FETCH_BRK;
            FETCH_BRK:
                state_nx = (data == BREAK_CODE) ? BREAK_WAIT : HOLD;  // repeated F0 keeps waiting
            HOLD:
                if (rel_ack)
                    state_nx = IDLE;
            default:
                state_nx = IDLE;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            state     <= IDLE;
            next_data <= 1'b0;
        end
        else
        begin
            state     <= state_nx;
            next_data <= (state_nx == FETCH) || (state_nx == FETCH_BRK);  // pop while fetching
        end
    end

    // previous code, steady through HOLD
    always_ff @(posedge clk)
    begin
        if (state == FETCH || state == FETCH_BRK)
            rel_code <= data;
    end

    assign rel_valid = (state == HOLD);

    a_ack_when_valid : assert property (@(posedge clk) disable iff (!rst)
        rel_ack |-> rel_valid)
        else $error("ps2_channel: acknowledge without a pending release");

endmodule

// File: verilog/release_arbiter.sv
`timescale 1ns/1ps

module release_arbiter (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [ps2_pkg::NUM_PORTS-1:0] rel_valid,
    input  ps2_pkg::scan_t                rel_code [ps2_pkg::NUM_PORTS],
    output logic [ps2_pkg::NUM_PORTS-1:0] rel_ack,
    output ps2_pkg::scan_t                key_code,
    output ps2_pkg::port_t                key_port,
    output logic                          key_strobe
);

    import ps2_pkg::*;

    port_t last_win;                                                  // rr pointer
    port_t win;
    logic  any_win;

    // search starts one past the last winner
    always_comb
    begin
        int idx;
        rel_ack = '0;
        win     = last_win;
        any_win = 1'b0;
        for (int off = 1; off <= NUM_PORTS; off++)
        begin
            idx = (int'(last_win) + off) % NUM_PORTS;
            if (!any_win && rel_valid[idx])
            begin
                any_win      = 1'b1;
                win          = port_t'(idx);
                rel_ack[idx] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            last_win   <= port_t'(NUM_PORTS - 1);                     // port 0 first
            key_code   <= '0;
            key_port   <= '0;
            key_strobe <= 1'b0;
        end
        else
        begin
            key_strobe <= any_win;
            if (any_win)
            begin
                last_win <= win;
                key_code <= rel_code[win];
                key_port <= win;
            end
        end
    end

    a_ack_onehot : assert property (@(posedge clk) disable iff (!rst)
        $onehot0(rel_ack))
        else $error("release_arbiter: more than one port acknowledged");

endmodule

// File: verilog/ps2_hub_top.sv
`timescale 1ns/1ps

module ps2_hub_top (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [ps2_pkg::NUM_PORTS-1:0] ps2_clk,
    input  logic [ps2_pkg::NUM_PORTS-1:0] ps2_dat,
    output ps2_pkg::scan_t                key_code,
    output ps2_pkg::port_t                key_port,
    output logic                          key_strobe
);

    import ps2_pkg::*;

    logic [NUM_PORTS-1:0] dat_s;
    logic [NUM_PORTS-1:0] fall;
    logic [NUM_PORTS-1:0] rel_valid;
    logic [NUM_PORTS-1:0] rel_ack;
    scan_t                rel_code [NUM_PORTS];

    ps2_sync sync_i (
        .clk     (clk),
        .rst     (rst),
        .ps2_clk (ps2_clk),
        .ps2_dat (ps2_dat),
        .dat_s   (dat_s),
        .fall    (fall)
    );

    // one receiver and decoder per port
    for (genvar i = 0; i < NUM_PORTS; i++)
    begin : g_port
        ps2_channel channel_i (
            .clk       (clk),
            .rst       (rst),
            .fall      (fall[i]),
            .dat_s     (dat_s[i]),
            .rel_ack   (rel_ack[i]),
            .rel_valid (rel_valid[i]),
            .rel_code  (rel_code[i])
        );
    end

    release_arbiter arbiter_i (
        .clk        (clk),
        .rst        (rst),
        .rel_valid  (rel_valid),
        .rel_code   (rel_code),
        .rel_ack    (rel_ack),
        .key_code   (key_code),
        .key_port   (key_port),
        .key_strobe (key_strobe)
    );

endmodule

// File: verification/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
    output logic clk
);

    localparam int HALF_PERIOD_NS = 2;                                // 4 ns period

    initial
    begin
        clk = 1'b0;
        forever #(HALF_PERIOD_NS) clk = ~clk;
    end

endmodule

// File: verification/ps2_hub_checker.sv
`timescale 1ns/1ps

module ps2_hub_checker (
    input  logic           clk,
    input  logic           rst,
    input  ps2_pkg::scan_t key_code,
    input  ps2_pkg::port_t key_port,
    input  logic           key_strobe
);

    import ps2_pkg::*;

    port_t exp_port_q [$];                                            // expected releases, in send order
    scan_t exp_code_q [$];
    string test_name    = "none";
    int    test_errors  = 0;
    int    error_count  = 0;
    int    tests_run    = 0;
    int    tests_failed = 0;

    task automatic note_error();
        test_errors++;
        error_count++;
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic expect_release(input port_t port, input scan_t code);
        exp_port_q.push_back(port);
        exp_code_q.push_back(code);
    endtask

    function automatic int pending();
        return exp_port_q.size();
    endfunction

    // ####################
    // strobe compare, oldest entry of the same port

    task automatic compare_strobe(input port_t port, input scan_t code);
        int idx;
        idx = -1;
        for (int i = 0; i < exp_port_q.size(); i++)
        begin
            if (idx < 0 && exp_port_q[i] == port)
                idx = i;
        end
        if (idx < 0)
        begin
            $display("%s: key strobe on port %0d with code %02h but no release was expected",
                     test_name, port, code);
            note_error();
        end
        else
        begin
            if (exp_code_q[idx] !== code)
            begin
                $display("ERR %s: port %0d expected %02h actual %02h",
                         test_name, port, exp_code_q[idx], code);
                note_error();
            end
            exp_port_q.delete(idx);
            exp_code_q.delete(idx);
        end
    endtask

    always @(posedge clk)
    begin
        if (rst && key_strobe)
            compare_strobe(key_port, key_code);
    end

    task automatic check_idle();
        if (key_strobe !== 1'b0)
        begin
            $display("ERR %s: key_strobe expected 0 actual %b", test_name, key_strobe);
            note_error();
        end
        if (key_code !== 8'h00)
        begin
            $display("ERR %s: key_code expected 00 actual %02h", test_name, key_code);
            note_error();
        end
    endtask

    task automatic finish_test();
        if (exp_port_q.size() != 0)
        begin
            $display("%s: %0d expected releases never came out of the hub",
                     test_name, exp_port_q.size());
            note_error();
            exp_port_q.delete();
            exp_code_q.delete();
        end
        tests_run++;
        if (test_errors != 0)
            tests_failed++;
        $display("test %s: %s, %0d errors", test_name, (test_errors == 0) ? "pass" : "FAIL",
                 test_errors);
    endtask

    task automatic report_summary();
        $display("tests run %0d, tests failed %0d, total errors %0d",
                 tests_run, tests_failed, error_count);
    endtask

endmodule

// File: verification/ps2_hub_tb.sv
`timescale 1ns/1ps

module ps2_hub_tb;

    import ps2_pkg::*;

    localparam int    HALF_BIT     = 20;                              // cycles per ps2 half period
    localparam int    N_MAKE       = 6;
    localparam int    N_RAND       = 20;
    localparam int    N_B2B        = 12;
    localparam int    MAX_SEQ      = 24;
    localparam int    IDLE_CYCLES  = 50;
    localparam int    DRAIN_LIMIT  = 200;
    localparam int    SETTLE       = 20;
    localparam int    TOTAL_FRAMES = 2 * N_MAKE + 9 + 3 + 2 * N_RAND + 2 * N_B2B;
    localparam longint WATCHDOG_NS = longint'(TOTAL_FRAMES) * 11 * 2 * HALF_BIT * 4
                                     + 6 * (DRAIN_LIMIT + SETTLE + IDLE_CYCLES) * 4 + 4000;

    logic                 clk;
    logic                 rst;
    logic [NUM_PORTS-1:0] ps2_clk;
    logic [NUM_PORTS-1:0] ps2_dat;
    scan_t                key_code;
    port_t                key_port;
    logic                 key_strobe;
    integer               seed;
    logic                 brk_seen [NUM_PORTS];                       // model saw a break prefix
    scan_t                stim [NUM_PORTS][MAX_SEQ];

    tb_clock clock_i (.clk(clk));

    ps2_hub_top ps2_hub_top_i (
        .clk        (clk),
        .rst        (rst),
        .ps2_clk    (ps2_clk),
        .ps2_dat    (ps2_dat),
        .key_code   (key_code),
        .key_port   (key_port),
        .key_strobe (key_strobe)
    );

    ps2_hub_checker checker_i (
        .clk        (clk),
        .rst        (rst),
        .key_code   (key_code),
        .key_port   (key_port),
        .key_strobe (key_strobe)
    );

    // ####################
    // reference model and stimulus

    task automatic model_byte(input int port, input scan_t b);
        if (brk_seen[port])
        begin
            if (b != BREAK_CODE)
            begin
                checker_i.expect_release(port_t'(port), b);
                brk_seen[port] = 1'b0;
            end
        end
        else if (b == BREAK_CODE)
            brk_seen[port] = 1'b1;
    endtask

    task automatic send_frame(input int port, input scan_t b, input logic bad_parity);
        logic [10:0] frame;
        logic        par;
        par   = ~^b ^ bad_parity;                                     // odd parity unless corrupted
        frame = {1'b1, par, b, 1'b0};
        if (!bad_parity)
            model_byte(port, b);
        @(negedge clk);
        for (int i = 0; i < 11; i++)
        begin
            ps2_dat[port] = frame[i];                                 // data moves while clock is high
            repeat (HALF_BIT) @(negedge clk);
            ps2_clk[port] = 1'b0;
            repeat (HALF_BIT) @(negedge clk);
            ps2_clk[port] = 1'b1;
        end
    endtask

    task automatic send_sequence(input int port, input int count);
        for (int i = 0; i < count; i++)
            send_frame(port, stim[port][i], 1'b0);
    endtask

    function automatic scan_t random_make();
        scan_t b;
        b = scan_t'($random(seed));
        if (b == BREAK_CODE)
            b = 8'h1C;
        return b;
    endfunction

    function automatic scan_t random_byte();
        logic [31:0] r;
        r = $random(seed);
        return (r[1:0] == 2'b00) ? BREAK_CODE : r[15:8];            // about one F0 in four
    endfunction

    task automatic drain();
        int waited;
        waited = 0;
        while (checker_i.pending() != 0 && waited < DRAIN_LIMIT)
        begin
            @(negedge clk);
            waited++;
        end
        repeat (SETTLE) @(negedge clk);
        checker_i.finish_test();
    endtask

    // ####################
    // test sequence

    initial
    begin
        seed    = 32'h935b_9903;
        rst     = 1'b0;
        ps2_clk = '1;
        ps2_dat = '1;
        for (int p = 0; p < NUM_PORTS; p++)
            brk_seen[p] = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;

        checker_i.start_test("reset_idle");
        for (int i = 0; i < IDLE_CYCLES; i++)
        begin
            @(negedge clk);
            checker_i.check_idle();
        end
        drain();

        checker_i.start_test("make_only");
        for (int i = 0; i < N_MAKE; i++)
        begin
            stim[0][i] = random_make();
            stim[1][i] = random_make();
        end
        fork
            send_sequence(0, N_MAKE);
            send_sequence(1, N_MAKE);
        join
        drain();

        checker_i.start_test("release_seq");
        send_frame(0, random_make(), 1'b0);
        send_frame(0, BREAK_CODE, 1'b0);
        send_frame(0, random_make(), 1'b0);
        send_frame(1, random_make(), 1'b0);
        send_frame(1, BREAK_CODE, 1'b0);
        send_frame(1, random_make(), 1'b0);
        send_frame(0, BREAK_CODE, 1'b0);
        send_frame(0, BREAK_CODE, 1'b0);                             // doubled prefix
        send_frame(0, random_make(), 1'b0);
        drain();

        checker_i.start_test("bad_parity");
        send_frame(1, random_make(), 1'b0);
        send_frame(1, BREAK_CODE, 1'b1);                             // dropped by the receiver
        send_frame(1, random_make(), 1'b0);
        drain();

        checker_i.start_test("random_both");
        for (int i = 0; i < N_RAND; i++)
        begin
            stim[0][i] = random_byte();
            stim[1][i] = random_byte();
        end
        fork
            send_sequence(0, N_RAND);
            send_sequence(1, N_RAND);
        join
        drain();

        checker_i.start_test("back_to_back");
        for (int i = 0; i < N_B2B; i++)
        begin
            stim[0][i] = (i % 2 == 0) ? BREAK_CODE : random_make();
            stim[1][i] = random_byte();
        end
        fork
            send_sequence(0, N_B2B);
            send_sequence(1, N_B2B);
        join
        drain();

        checker_i.report_summary();
        if (checker_i.error_count == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("watchdog expired before all tests finished");
        $display("Errors found");
        $finish;
    end

endmodule

// File: sources.f
verilog/ps2_pkg.sv
verilog/ps2_sync.sv
verilog/ps2_frame_rx.sv
verilog/ps2_channel.sv
verilog/release_arbiter.sv
verilog/ps2_hub_top.sv
verification/tb_clock.sv
verification/ps2_hub_checker.sv
verification/ps2_hub_tb.sv
